// File: design/mrc_fmt_pkg.sv
package mrc_fmt_pkg;

  // --------------------
  // beat delineator
  // --------------------

  typedef logic [1:0] cntl_t;

  localparam cntl_t CNTL_MOM     = 2'd0;
  localparam cntl_t CNTL_SOM     = 2'd1;
  localparam cntl_t CNTL_EOM     = 2'd2;
  localparam cntl_t CNTL_SOM_EOM = 2'd3;

  // --------------------
  // option tuples
  // --------------------

  localparam int OPT_PER_BEAT = 3;

  typedef logic [3:0] opt_type_t;
  typedef logic [7:0] opt_value_t;

  localparam opt_type_t OPT_NOP       = 4'd0;
  localparam opt_type_t OPT_NUM_LANES = 4'd1;
  localparam opt_type_t OPT_MEMORY    = 4'd2;
  localparam opt_type_t OPT_TARGET    = 4'd3;
  localparam opt_type_t OPT_TXFER     = 4'd4;

  // extended tuple, value then next type then next value, msb first
  typedef logic [2*$bits(opt_value_t)+$bits(opt_type_t)-1:0] storage_ptr_t;

  // --------------------
  // extracted descriptor
  // --------------------

  typedef struct packed {
    opt_value_t   num_lanes;
    storage_ptr_t storage_ptr;
    opt_value_t   txfer_type;
    opt_value_t   target;
  } mr_desc_t;

endpackage

// File: design/sdmem_pkg.sv
package sdmem_pkg;
  import mrc_fmt_pkg::*;

  // storage descriptor memory, addressed by low bits of the pointer
  localparam int SD_DEPTH = 16;
  typedef logic [$clog2(SD_DEPTH)-1:0] sd_addr_t;

  // consecutive/jump memory, pointer wraps
  localparam int CJ_DEPTH = 32;
  typedef logic [$clog2(CJ_DEPTH)-1:0] cj_addr_t;

  typedef logic [31:0] dram_addr_t;
  typedef logic [7:0]  access_order_t;
  typedef logic [15:0] cons_jump_t;

  typedef struct packed {
    dram_addr_t    dram_addr;
    access_order_t access_order;
    cj_addr_t      cj_ptr;
  } sd_entry_t;

  typedef struct packed {
    cntl_t      cntl;
    cons_jump_t cons_jump;
  } cj_entry_t;

endpackage

// File: design/mrc_desc_if.sv
`timescale 1ns/1ps

// queued descriptor beats, transfer when valid and read are both high
interface mrc_desc_if
  import mrc_fmt_pkg::*;
  ();

  logic       valid;
  logic       read;
  cntl_t      cntl;
  opt_type_t  opt_type  [OPT_PER_BEAT];
  opt_value_t opt_value [OPT_PER_BEAT];

  modport source (
    output valid, cntl, opt_type, opt_value,
    input  read
  );

  modport sink (
    input  valid, cntl, opt_type, opt_value,
    output read
  );

endinterface

// File: design/desc_queue.sv
`timescale 1ns/1ps

module desc_queue
  import mrc_fmt_pkg::*;
#(
  parameter int FIFO_DEPTH     = 8,
  parameter int FIFO_THRESHOLD = 6
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  input  cntl_t      in_cntl,
  input  opt_type_t  in_opt_type  [OPT_PER_BEAT],
  input  opt_value_t in_opt_value [OPT_PER_BEAT],
  output logic       in_ready,
  mrc_desc_if.source q
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // registered input beat
  logic       in_valid_d1;
  cntl_t      in_cntl_d1;
  opt_type_t  in_opt_type_d1  [OPT_PER_BEAT];
  opt_value_t in_opt_value_d1 [OPT_PER_BEAT];

  // fifo array and pointers
  cntl_t            mem_cntl  [FIFO_DEPTH];
  opt_type_t        mem_type  [FIFO_DEPTH][OPT_PER_BEAT];
  opt_value_t       mem_value [FIFO_DEPTH][OPT_PER_BEAT];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             fifo_wr;
  logic             fifo_rd;
  logic             empty;
  logic             almost_full;

  // fifo output stage
  logic       out_valid;
  logic       out_read;
  cntl_t      out_cntl;
  opt_type_t  out_opt_type  [OPT_PER_BEAT];
  opt_value_t out_opt_value [OPT_PER_BEAT];

  // pipe stage, drives the interface
  logic       pipe_valid;
  logic       pipe_read;
  cntl_t      pipe_cntl;
  opt_type_t  pipe_opt_type  [OPT_PER_BEAT];
  opt_value_t pipe_opt_value [OPT_PER_BEAT];

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // --------------------
  // input register
  // --------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      in_valid_d1 <= 1'b0;
      in_ready    <= 1'b0;
    end
    else
    begin
      in_valid_d1 <= in_valid;
      in_ready    <= ~almost_full;
    end
  end

  always_ff @(posedge clk)
  begin
    in_cntl_d1      <= in_cntl;
    in_opt_type_d1  <= in_opt_type;
    in_opt_value_d1 <= in_opt_value;
  end

  // --------------------
  // fifo
  // --------------------

  assign fifo_wr     = in_valid_d1;
  assign empty       = (count == '0);
  // headroom above threshold covers beats already in flight
  assign almost_full = (count >= CNT_W'(FIFO_THRESHOLD));

  // keep output stage and pipe stage charged
  assign fifo_rd   = ~empty & (~out_valid | out_read);
  assign out_read  = out_valid & (~pipe_valid | pipe_read);
  assign pipe_read = pipe_valid & q.read;

  always_ff @(posedge clk)
  begin
    if (fifo_wr)
    begin
      mem_cntl[wr_ptr]  <= in_cntl_d1;
      mem_type[wr_ptr]  <= in_opt_type_d1;
      mem_value[wr_ptr] <= in_opt_value_d1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      out_valid  <= 1'b0;
      pipe_valid <= 1'b0;
    end
    else
    begin
      if (fifo_wr)
        wr_ptr <= ptr_inc(wr_ptr);
      if (fifo_rd)
        rd_ptr <= ptr_inc(rd_ptr);
      count <= count + CNT_W'(fifo_wr) - CNT_W'(fifo_rd);
      if (fifo_rd)
        out_valid <= 1'b1;
      else if (out_read)
        out_valid <= 1'b0;
      if (out_read)
        pipe_valid <= 1'b1;
      else if (pipe_read)
        pipe_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fifo_rd)
    begin
      out_cntl      <= mem_cntl[rd_ptr];
      out_opt_type  <= mem_type[rd_ptr];
      out_opt_value <= mem_value[rd_ptr];
    end
    if (out_read)
    begin
      pipe_cntl      <= out_cntl;
      pipe_opt_type  <= out_opt_type;
      pipe_opt_value <= out_opt_value;
    end
  end

  assign q.valid     = pipe_valid;
  assign q.cntl      = pipe_cntl;
  assign q.opt_type  = pipe_opt_type;
  assign q.opt_value = pipe_opt_value;

endmodule

// File: design/desc_sequencer.sv
`timescale 1ns/1ps

module desc_sequencer
  import mrc_fmt_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  mrc_desc_if.sink q,
  input  logic     done,
  output logic     start,
  output mr_desc_t desc,
  output logic     error
);

  typedef enum logic [2:0] {
    WAIT,
    EXTRACT,
    START,
    RUN,
    COMPLETE,
    ERR
  } state_t;

  state_t state;
  state_t state_next;

  logic beat;
  logic capture;

  // per-beat option matches
  logic         lanes_hit;
  opt_value_t   lanes_val;
  logic         ptr_hit;
  storage_ptr_t ptr_val;
  logic         txfer_hit;
  opt_value_t   txfer_val;
  logic         target_hit;
  opt_value_t   target_val;

  assign q.read  = (state == WAIT) || (state == EXTRACT);
  assign beat    = q.valid && q.read;
  // an error beat in WAIT is dropped without capture
  assign capture = beat && ((state == EXTRACT) || (q.cntl == CNTL_SOM));

  assign start = (state == START);
  assign error = (state == ERR);

  // --------------------
  // state machine
  // --------------------

  always_comb
  begin
    state_next = state;
    case (state)
      WAIT:
        if (beat)
          state_next = (q.cntl == CNTL_SOM) ? EXTRACT : ERR;
      EXTRACT:
        if (beat && (q.cntl == CNTL_EOM))
          state_next = START;
      START:
        state_next = RUN;
      RUN:
        if (done)
          state_next = COMPLETE;
      COMPLETE:
        state_next = WAIT;
      ERR:
        state_next = ERR;
      default:
        state_next = WAIT;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= WAIT;
    else
      state <= state_next;
  end

  // --------------------
  // option decode
  // --------------------

  // scan high to low so the lowest tuple wins
  always_comb
  begin
    lanes_hit  = 1'b0;
    lanes_val  = '0;
    txfer_hit  = 1'b0;
    txfer_val  = '0;
    target_hit = 1'b0;
    target_val = '0;
    for (int i = OPT_PER_BEAT - 1; i >= 0; i--)
    begin
      if (q.opt_type[i] == OPT_NUM_LANES)
      begin
        lanes_hit = 1'b1;
        lanes_val = q.opt_value[i];
      end
      if (q.opt_type[i] == OPT_TXFER)
      begin
        txfer_hit = 1'b1;
        txfer_val = q.opt_value[i];
      end
      if (q.opt_type[i] == OPT_TARGET)
      begin
        target_hit = 1'b1;
        target_val = q.opt_value[i];
      end
    end
    // extended tuple needs the tuple after it
    ptr_hit = 1'b0;
    ptr_val = '0;
    if (q.opt_type[1] == OPT_MEMORY)
    begin
      ptr_hit = 1'b1;
      ptr_val = {q.opt_value[1], q.opt_type[2], q.opt_value[2]};
    end
    if (q.opt_type[0] == OPT_MEMORY)
    begin
      ptr_hit = 1'b1;
      ptr_val = {q.opt_value[0], q.opt_type[1], q.opt_value[1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      desc <= '0;
    else if (state == COMPLETE)
      desc <= '0;
    else if (capture)
    begin
      if (lanes_hit)
        desc.num_lanes <= lanes_val;
      if (ptr_hit)
        desc.storage_ptr <= ptr_val;
      if (txfer_hit)
        desc.txfer_type <= txfer_val;
      if (target_hit)
        desc.target <= target_val;
    end
  end

endmodule

// File: design/storage_desc_walk.sv
`timescale 1ns/1ps

module storage_desc_walk
  import mrc_fmt_pkg::*;
  import sdmem_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          start,
  input  mr_desc_t      desc,
  input  logic          sd_wr_en,
  input  sd_addr_t      sd_wr_addr,
  input  sd_entry_t     sd_wr_data,
  input  logic          cj_wr_en,
  input  cj_addr_t      cj_wr_addr,
  input  cj_entry_t     cj_wr_data,
  output logic          done,
  output logic          access_valid,
  output logic          access_last,
  output dram_addr_t    access_dram_addr,
  output access_order_t access_order,
  output cons_jump_t    access_cons_jump,
  output opt_value_t    access_num_lanes,
  output opt_value_t    access_txfer_type,
  output opt_value_t    access_target
);

  sd_entry_t sd_mem [SD_DEPTH];
  cj_entry_t cj_mem [CJ_DEPTH];
  sd_entry_t sd_q;
  cj_entry_t cj_q;
  sd_addr_t  sd_rd_addr;
  cj_addr_t  cj_rd_addr;
  cj_addr_t  cj_next;
  logic      sd_phase;
  logic      cj_phase;
  logic      cj_end;

  // upper pointer bits select the manager and are not used here
  assign sd_rd_addr = desc.storage_ptr[$bits(sd_addr_t)-1:0];
  // first cj address comes straight from the sd entry
  assign cj_rd_addr = sd_phase ? sd_q.cj_ptr : cj_next;
  assign cj_end     = (cj_q.cntl == CNTL_EOM) || (cj_q.cntl == CNTL_SOM_EOM);

  // --------------------
  // memories
  // --------------------

  always_ff @(posedge clk)
  begin
    if (sd_wr_en)
      sd_mem[sd_wr_addr] <= sd_wr_data;
    if (start)
      sd_q <= sd_mem[sd_rd_addr];
  end

  always_ff @(posedge clk)
  begin
    if (cj_wr_en)
      cj_mem[cj_wr_addr] <= cj_wr_data;
    cj_q <= cj_mem[cj_rd_addr];
  end

  // --------------------
  // walk control
  // --------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sd_phase     <= 1'b0;
      cj_phase     <= 1'b0;
      access_valid <= 1'b0;
      access_last  <= 1'b0;
      done         <= 1'b0;
    end
    else
    begin
      sd_phase <= start;
      if (sd_phase)
        cj_phase <= 1'b1;
      else if (cj_phase && cj_end)
        cj_phase <= 1'b0;
      access_valid <= cj_phase;
      access_last  <= cj_phase && cj_end;
      done         <= cj_phase && cj_end;
    end
  end

  // one record per cj entry, pointer wraps at memory size
  always_ff @(posedge clk)
  begin
    cj_next <= cj_rd_addr + 1'b1;
    if (cj_phase)
    begin
      access_dram_addr  <= sd_q.dram_addr;
      access_order      <= sd_q.access_order;
      access_cons_jump  <= cj_q.cons_jump;
      access_num_lanes  <= desc.num_lanes;
      access_txfer_type <= desc.txfer_type;
      access_target     <= desc.target;
    end
  end

endmodule

// File: design/mrc_cntl.sv
`timescale 1ns/1ps

module mrc_cntl
  import mrc_fmt_pkg::*;
  import sdmem_pkg::*;
#(
  parameter int FIFO_DEPTH     = 8,
  parameter int FIFO_THRESHOLD = 6
) (
  input  logic          clk,
  input  logic          rst_n,
  // descriptor beats from the decoder
  input  logic          desc_valid,
  input  cntl_t         desc_cntl,
  input  opt_type_t     desc_opt_type  [OPT_PER_BEAT],
  input  opt_value_t    desc_opt_value [OPT_PER_BEAT],
  output logic          desc_ready,
  // memory load ports
  input  logic          sd_wr_en,
  input  sd_addr_t      sd_wr_addr,
  input  sd_entry_t     sd_wr_data,
  input  logic          cj_wr_en,
  input  cj_addr_t      cj_wr_addr,
  input  cj_entry_t     cj_wr_data,
  // access records
  output logic          access_valid,
  output logic          access_last,
  output dram_addr_t    access_dram_addr,
  output access_order_t access_order,
  output cons_jump_t    access_cons_jump,
  output opt_value_t    access_num_lanes,
  output opt_value_t    access_txfer_type,
  output opt_value_t    access_target,
  // status
  output logic          desc_done,
  output logic          desc_error
);

  mrc_desc_if q_if ();

  logic     start;
  mr_desc_t desc;

  desc_queue #(
    .FIFO_DEPTH     (FIFO_DEPTH),
    .FIFO_THRESHOLD (FIFO_THRESHOLD)
  ) u_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (desc_valid),
    .in_cntl      (desc_cntl),
    .in_opt_type  (desc_opt_type),
    .in_opt_value (desc_opt_value),
    .in_ready     (desc_ready),
    .q            (q_if.source)
  );

  desc_sequencer u_seq (
    .clk   (clk),
    .rst_n (rst_n),
    .q     (q_if.sink),
    .done  (desc_done),
    .start (start),
    .desc  (desc),
    .error (desc_error)
  );

  storage_desc_walk u_walk (
    .clk               (clk),
    .rst_n             (rst_n),
    .start             (start),
    .desc              (desc),
    .sd_wr_en          (sd_wr_en),
    .sd_wr_addr        (sd_wr_addr),
    .sd_wr_data        (sd_wr_data),
    .cj_wr_en          (cj_wr_en),
    .cj_wr_addr        (cj_wr_addr),
    .cj_wr_data        (cj_wr_data),
    .done              (desc_done),
    .access_valid      (access_valid),
    .access_last       (access_last),
    .access_dram_addr  (access_dram_addr),
    .access_order      (access_order),
    .access_cons_jump  (access_cons_jump),
    .access_num_lanes  (access_num_lanes),
    .access_txfer_type (access_txfer_type),
    .access_target     (access_target)
  );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

// free running testbench clock
module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

// File: testbench/mrc_cntl_tb.sv
`timescale 1ns/1ps

module mrc_cntl_tb
  import mrc_fmt_pkg::*;
  import sdmem_pkg::*;
();

  // roughly ten times the longest expected run
  localparam int TIMEOUT_CYCLES = 6000;

  typedef struct packed {
    cntl_t                         cntl;
    opt_type_t  [OPT_PER_BEAT-1:0] typ;
    opt_value_t [OPT_PER_BEAT-1:0] val;
  } beat_t;

  typedef struct packed {
    logic          last;
    dram_addr_t    dram_addr;
    access_order_t order;
    cons_jump_t    cons_jump;
    opt_value_t    num_lanes;
    opt_value_t    txfer_type;
    opt_value_t    target;
  } rec_t;

  logic          clk;
  logic          rst_n;
  logic          desc_valid;
  cntl_t         desc_cntl;
  opt_type_t     desc_opt_type  [OPT_PER_BEAT];
  opt_value_t    desc_opt_value [OPT_PER_BEAT];
  logic          desc_ready;
  logic          sd_wr_en;
  sd_addr_t      sd_wr_addr;
  sd_entry_t     sd_wr_data;
  logic          cj_wr_en;
  cj_addr_t      cj_wr_addr;
  cj_entry_t     cj_wr_data;
  logic          access_valid;
  logic          access_last;
  dram_addr_t    access_dram_addr;
  access_order_t access_order;
  cons_jump_t    access_cons_jump;
  opt_value_t    access_num_lanes;
  opt_value_t    access_txfer_type;
  opt_value_t    access_target;
  logic          desc_done;
  logic          desc_error;

  // model state and bookkeeping
  sd_entry_t   sd_model [SD_DEPTH];
  cj_entry_t   cj_model [CJ_DEPTH];
  beat_t       cur_q [$];
  beat_t       pend_q [$];
  rec_t        exp_q [$];
  rec_t        got_q [$];
  rec_t        seen_rec;
  logic [15:0] lfsr;
  int          done_count;
  int          cycle_count;
  int          error_count;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;
  string       test_name;
  bit          ready_fell;
  bit          ready_rose;

  tb_clock #(.PERIOD_NS(40)) u_clock (.clk(clk));

  mrc_cntl #(
    .FIFO_DEPTH     (8),
    .FIFO_THRESHOLD (6)
  ) dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .desc_valid        (desc_valid),
    .desc_cntl         (desc_cntl),
    .desc_opt_type     (desc_opt_type),
    .desc_opt_value    (desc_opt_value),
    .desc_ready        (desc_ready),
    .sd_wr_en          (sd_wr_en),
    .sd_wr_addr        (sd_wr_addr),
    .sd_wr_data        (sd_wr_data),
    .cj_wr_en          (cj_wr_en),
    .cj_wr_addr        (cj_wr_addr),
    .cj_wr_data        (cj_wr_data),
    .access_valid      (access_valid),
    .access_last       (access_last),
    .access_dram_addr  (access_dram_addr),
    .access_order      (access_order),
    .access_cons_jump  (access_cons_jump),
    .access_num_lanes  (access_num_lanes),
    .access_txfer_type (access_txfer_type),
    .access_target     (access_target),
    .desc_done         (desc_done),
    .desc_error        (desc_error)
  );

  // --------------------
  // random numbers
  // --------------------

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  // --------------------
  // reporting
  // --------------------

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
    error_count++;
  endtask

  task automatic report_failure(input string what);
    $display("[ERROR] %s", what);
    error_count++;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = error_count;
    tests_run++;
    got_q.delete();
    exp_q.delete();
    done_count = 0;
    ready_fell = 1'b0;
    ready_rose = 1'b0;
  endtask

  task automatic end_test();
    if (error_count == errors_at_start)
      $display("test %-14s passed", test_name);
    else
    begin
      $display("test %-14s failed with %0d errors", test_name, error_count - errors_at_start);
      tests_failed++;
    end
  endtask

  // --------------------
  // memory loading
  // --------------------

  task automatic write_sd(input sd_addr_t addr, input cj_addr_t cj_ptr);
    sd_entry_t e;
    e.dram_addr    = rand_bits(32);
    e.access_order = access_order_t'(rand_bits(8));
    e.cj_ptr       = cj_ptr;
    @(posedge clk);
    #1;
    sd_wr_en   = 1'b1;
    sd_wr_addr = addr;
    sd_wr_data = e;
    sd_model[addr] = e;
  endtask

  task automatic write_cj(input cj_addr_t addr, input cntl_t cntl);
    cj_entry_t e;
    e.cntl      = cntl;
    e.cons_jump = cons_jump_t'(rand_bits(16));
    @(posedge clk);
    #1;
    cj_wr_en   = 1'b1;
    cj_wr_addr = addr;
    cj_wr_data = e;
    cj_model[addr] = e;
  endtask

  task automatic end_writes();
    @(posedge clk);
    #1;
    sd_wr_en = 1'b0;
    cj_wr_en = 1'b0;
  endtask

  // end_mask marks the cj entries that end a message
  task automatic load_memories(input logic [31:0] end_mask);
    for (int i = 0; i < SD_DEPTH; i++)
      write_sd(sd_addr_t'(i), cj_addr_t'(rand_bits(5)));
    for (int i = 0; i < CJ_DEPTH; i++)
      write_cj(cj_addr_t'(i), end_mask[i] ? CNTL_EOM : CNTL_MOM);
    end_writes();
  endtask

  // --------------------
  // reference model
  // --------------------

  task automatic add_beat(input cntl_t c, input opt_type_t t0, input opt_value_t v0,
                          input opt_type_t t1, input opt_value_t v1,
                          input opt_type_t t2, input opt_value_t v2);
    beat_t b;
    b.cntl   = c;
    b.typ[0] = t0;
    b.val[0] = v0;
    b.typ[1] = t1;
    b.val[1] = v1;
    b.typ[2] = t2;
    b.val[2] = v2;
    cur_q.push_back(b);
  endtask

  // fields start at 0, lowest tuple wins in a beat, later beats overwrite
  function automatic mr_desc_t model_fields();
    mr_desc_t f;
    bit       lanes_seen;
    bit       txfer_seen;
    bit       target_seen;
    f = '0;
    foreach (cur_q[b])
    begin
      lanes_seen  = 1'b0;
      txfer_seen  = 1'b0;
      target_seen = 1'b0;
      for (int i = 0; i < OPT_PER_BEAT; i++)
      begin
        if (!lanes_seen && cur_q[b].typ[i] == OPT_NUM_LANES)
        begin
          f.num_lanes = cur_q[b].val[i];
          lanes_seen  = 1'b1;
        end
        if (!txfer_seen && cur_q[b].typ[i] == OPT_TXFER)
        begin
          f.txfer_type = cur_q[b].val[i];
          txfer_seen   = 1'b1;
        end
        if (!target_seen && cur_q[b].typ[i] == OPT_TARGET)
        begin
          f.target    = cur_q[b].val[i];
          target_seen = 1'b1;
        end
      end
      // extended tuple, can only start in tuple 0 or 1
      if (cur_q[b].typ[0] == OPT_MEMORY)
        f.storage_ptr = {cur_q[b].val[0], cur_q[b].typ[1], cur_q[b].val[1]};
      else if (cur_q[b].typ[1] == OPT_MEMORY)
        f.storage_ptr = {cur_q[b].val[1], cur_q[b].typ[2], cur_q[b].val[2]};
    end
    return f;
  endfunction

  function automatic void model_walk(input mr_desc_t f);
    sd_entry_t sd;
    cj_addr_t  ptr;
    rec_t      r;
    int        steps;
    sd     = sd_model[sd_addr_t'(f.storage_ptr)];
    ptr    = sd.cj_ptr;
    steps  = 0;
    r.last = 1'b0;
    while (!r.last && steps < CJ_DEPTH)
    begin
      r.last       = (cj_model[ptr].cntl == CNTL_EOM) || (cj_model[ptr].cntl == CNTL_SOM_EOM);
      r.dram_addr  = sd.dram_addr;
      r.order      = sd.access_order;
      r.cons_jump  = cj_model[ptr].cons_jump;
      r.num_lanes  = f.num_lanes;
      r.txfer_type = f.txfer_type;
      r.target     = f.target;
      exp_q.push_back(r);
      ptr = cj_addr_t'(ptr + 1);
      steps++;
    end
  endfunction

  task automatic close_desc(input bit modeled);
    if (modeled)
      model_walk(model_fields());
    foreach (cur_q[i])
      pend_q.push_back(cur_q[i]);
    cur_q.delete();
  endtask

  // --------------------
  // driving and checking
  // --------------------

  task automatic drive_beat(input beat_t b);
    desc_valid = 1'b1;
    desc_cntl  = b.cntl;
    for (int i = 0; i < OPT_PER_BEAT; i++)
    begin
      desc_opt_type[i]  = b.typ[i];
      desc_opt_value[i] = b.val[i];
    end
  endtask

  // one beat per cycle while desc_ready is seen high
  task automatic send_pending();
    beat_t b;
    while (pend_q.size() > 0)
    begin
      @(posedge clk);
      #1;
      if (desc_ready)
      begin
        b = pend_q.pop_front();
        drive_beat(b);
      end
      else
        desc_valid = 1'b0;
    end
    @(posedge clk);
    #1;
    desc_valid = 1'b0;
  endtask

  task automatic wait_done(input int n);
    while (done_count < n)
      @(negedge clk);
    repeat (4) @(negedge clk);
    if (done_count != n)
      report_failure($sformatf("saw %0d desc_done pulses, expected %0d", done_count, n));
  endtask

  task automatic check_records();
    rec_t want;
    rec_t got;
    int   n;
    if (got_q.size() != exp_q.size())
      report_failure($sformatf("got %0d access records, expected %0d",
                               got_q.size(), exp_q.size()));
    n = 0;
    while (exp_q.size() > 0 && got_q.size() > 0)
    begin
      want = exp_q.pop_front();
      got  = got_q.pop_front();
      if (got.last !== want.last)
        report_mismatch($sformatf("access_last[%0d]", n), got.last, want.last);
      if (got.dram_addr !== want.dram_addr)
        report_mismatch($sformatf("access_dram_addr[%0d]", n), got.dram_addr, want.dram_addr);
      if (got.order !== want.order)
        report_mismatch($sformatf("access_order[%0d]", n), got.order, want.order);
      if (got.cons_jump !== want.cons_jump)
        report_mismatch($sformatf("access_cons_jump[%0d]", n), got.cons_jump, want.cons_jump);
      if (got.num_lanes !== want.num_lanes)
        report_mismatch($sformatf("access_num_lanes[%0d]", n), got.num_lanes, want.num_lanes);
      if (got.txfer_type !== want.txfer_type)
        report_mismatch($sformatf("access_txfer_type[%0d]", n), got.txfer_type,
                        want.txfer_type);
      if (got.target !== want.target)
        report_mismatch($sformatf("access_target[%0d]", n), got.target, want.target);
      n++;
    end
    exp_q.delete();
    got_q.delete();
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n      = 1'b0;
    desc_valid = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // --------------------
  // tests
  // --------------------

  task automatic test_reset();
    begin_test("reset");
    repeat (10)
    begin
      @(negedge clk);
      if (desc_ready !== 1'b0)
        report_mismatch("desc_ready", desc_ready, 0);
      if (access_valid !== 1'b0)
        report_mismatch("access_valid", access_valid, 0);
      if (desc_done !== 1'b0)
        report_mismatch("desc_done", desc_done, 0);
      if (desc_error !== 1'b0)
        report_mismatch("desc_error", desc_error, 0);
    end
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (desc_ready !== 1'b0)
      report_mismatch("desc_ready", desc_ready, 0);
    if (access_valid !== 1'b0)
      report_mismatch("access_valid", access_valid, 0);
    if (desc_done !== 1'b0)
      report_mismatch("desc_done", desc_done, 0);
    if (desc_error !== 1'b0)
      report_mismatch("desc_error", desc_error, 0);
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
    if (desc_ready !== 1'b1)
      report_mismatch("desc_ready", desc_ready, 1);
    end_test();
  endtask

  task automatic test_basic_walk();
    begin_test("basic_walk");
    load_memories(32'h0000_1000);
    write_sd(sd_addr_t'(5), cj_addr_t'(10));
    end_writes();
    // pointer in tuple 0, type nibble kept above the option codes
    add_beat(CNTL_SOM, OPT_MEMORY, opt_value_t'(rand_bits(8)),
             opt_type_t'(8 + rand_bits(3)), opt_value_t'(rand_bits(4) * 16 + 5),
             OPT_TARGET, opt_value_t'(rand_bits(8)));
    add_beat(CNTL_EOM, OPT_TXFER, opt_value_t'(rand_bits(8)),
             OPT_NUM_LANES, opt_value_t'(rand_bits(8)), OPT_NOP, 8'h00);
    close_desc(1'b1);
    send_pending();
    wait_done(1);
    check_records();
    end_test();
  endtask

  task automatic test_field_rules();
    begin_test("field_rules");
    load_memories(32'h0000_0020);
    write_cj(cj_addr_t'(0), CNTL_SOM_EOM);
    write_sd(sd_addr_t'(9), cj_addr_t'(3));
    write_sd(sd_addr_t'(2), cj_addr_t'(30));
    end_writes();
    // pointer in tuple 1, num_lanes overridden by the EOM beat
    add_beat(CNTL_SOM, OPT_NUM_LANES, opt_value_t'(rand_bits(8)),
             OPT_MEMORY, opt_value_t'(rand_bits(8)),
             opt_type_t'(8 + rand_bits(3)), opt_value_t'(rand_bits(4) * 16 + 9));
    add_beat(CNTL_MOM, OPT_TARGET, opt_value_t'(rand_bits(8)),
             OPT_TXFER, opt_value_t'(rand_bits(8)), OPT_NOP, 8'h00);
    add_beat(CNTL_EOM, OPT_NUM_LANES, opt_value_t'(rand_bits(8)),
             OPT_NOP, 8'h00, OPT_NOP, 8'h00);
    close_desc(1'b1);
    // no target here, walk wraps 30, 31, 0
    add_beat(CNTL_SOM, OPT_MEMORY, opt_value_t'(rand_bits(8)),
             opt_type_t'(8 + rand_bits(3)), opt_value_t'(rand_bits(4) * 16 + 2),
             OPT_NUM_LANES, opt_value_t'(rand_bits(8)));
    add_beat(CNTL_EOM, OPT_TXFER, opt_value_t'(rand_bits(8)),
             OPT_NOP, 8'h00, OPT_NOP, 8'h00);
    close_desc(1'b1);
    send_pending();
    wait_done(2);
    check_records();
    end_test();
  endtask

  task automatic test_back_pressure();
    begin_test("back_pressure");
    load_memories(32'h8000_8000);
    // walks of 9 to 16 entries
    for (int k = 0; k < 6; k++)
      write_sd(sd_addr_t'(k), cj_addr_t'(rand_bits(1) * 16 + rand_bits(3)));
    end_writes();
    for (int k = 0; k < 6; k++)
    begin
      add_beat(CNTL_SOM, OPT_NUM_LANES, opt_value_t'(rand_bits(8)),
               OPT_TARGET, opt_value_t'(rand_bits(8)), OPT_NOP, 8'h00);
      add_beat(CNTL_MOM, OPT_MEMORY, opt_value_t'(rand_bits(8)),
               opt_type_t'(8 + rand_bits(3)), opt_value_t'(rand_bits(4) * 16 + k),
               OPT_NOP, 8'h00);
      add_beat(CNTL_EOM, OPT_TXFER, opt_value_t'(rand_bits(8)),
               OPT_NOP, 8'h00, OPT_NOP, 8'h00);
      close_desc(1'b1);
    end
    send_pending();
    wait_done(6);
    if (!ready_fell)
      report_failure("desc_ready never fell while the walks were running");
    if (!ready_rose)
      report_failure("desc_ready did not rise again after falling");
    check_records();
    end_test();
  endtask

  task automatic test_error();
    int  wait_cycles;
    bit  dropped;
    begin_test("error");
    apply_reset();
    add_beat(CNTL_MOM, OPT_NUM_LANES, opt_value_t'(rand_bits(8)),
             OPT_NOP, 8'h00, OPT_NOP, 8'h00);
    close_desc(1'b0);
    send_pending();
    wait_cycles = 0;
    while (!desc_error && wait_cycles < 20)
    begin
      @(negedge clk);
      wait_cycles++;
    end
    if (desc_error !== 1'b1)
      report_failure("desc_error did not rise after a first beat without SOM");
    dropped = 1'b0;
    repeat (50)
    begin
      @(negedge clk);
      if (desc_error !== 1'b1)
        dropped = 1'b1;
    end
    if (dropped)
      report_failure("desc_error fell before the next reset");
    // a valid descriptor after the error is never processed
    add_beat(CNTL_SOM, OPT_NUM_LANES, opt_value_t'(rand_bits(8)),
             OPT_MEMORY, 8'h00, 4'h8, 8'h00);
    add_beat(CNTL_EOM, OPT_TXFER, opt_value_t'(rand_bits(8)),
             OPT_NOP, 8'h00, OPT_NOP, 8'h00);
    close_desc(1'b0);
    send_pending();
    repeat (50) @(negedge clk);
    if (desc_error !== 1'b1)
      report_mismatch("desc_error", desc_error, 1);
    if (got_q.size() != 0)
      report_failure($sformatf("%0d access records appeared after the error", got_q.size()));
    if (done_count != 0)
      report_failure("desc_done pulsed after the error");
    end_test();
  endtask

  // --------------------
  // monitor and watchdog
  // --------------------

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (access_valid)
      begin
        seen_rec.last       = access_last;
        seen_rec.dram_addr  = access_dram_addr;
        seen_rec.order      = access_order;
        seen_rec.cons_jump  = access_cons_jump;
        seen_rec.num_lanes  = access_num_lanes;
        seen_rec.txfer_type = access_txfer_type;
        seen_rec.target     = access_target;
        got_q.push_back(seen_rec);
      end
      if (desc_done)
        done_count++;
      if (!desc_ready)
        ready_fell = 1'b1;
      else if (ready_fell)
        ready_rose = 1'b1;
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout, run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  initial
  begin
    lfsr         = 16'h0001;
    cycle_count  = 0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    desc_valid   = 1'b0;
    desc_cntl    = CNTL_MOM;
    for (int i = 0; i < OPT_PER_BEAT; i++)
    begin
      desc_opt_type[i]  = OPT_NOP;
      desc_opt_value[i] = '0;
    end
    sd_wr_en   = 1'b0;
    sd_wr_addr = '0;
    sd_wr_data = '0;
    cj_wr_en   = 1'b0;
    cj_wr_addr = '0;
    cj_wr_data = '0;
    test_reset();
    test_basic_walk();
    test_field_rules();
    test_back_pressure();
    test_error();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: vlog.f
design/mrc_fmt_pkg.sv
design/sdmem_pkg.sv
design/mrc_desc_if.sv
design/desc_queue.sv
design/desc_sequencer.sv
design/storage_desc_walk.sv
design/mrc_cntl.sv
testbench/tb_clock.sv
testbench/mrc_cntl_tb.sv

// File: Makefile
# Verilator build and run for the memory read controller testbench

VERILATOR ?= verilator
TOP       ?= mrc_cntl_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
